// ==== verilog/mul_pkg.sv ====
`default_nettype none

package mul_pkg;

    // operand and result widths
    typedef logic [31:0] word_t;
    typedef logic [63:0] dword_t;

    // tags carried with every multiply
    typedef logic [6:0]  preg_t;
    typedef logic [6:0]  rs_id_t;
    typedef logic [31:0] pc_t;

    // multiply kind, low bits of funct3
    typedef logic [1:0]  mul_funct_t;

    localparam mul_funct_t FUNCT_MUL    = 2'b00;
    localparam mul_funct_t FUNCT_MULH   = 2'b01;
    localparam mul_funct_t FUNCT_MULHSU = 2'b10;
    localparam mul_funct_t FUNCT_MULHU  = 2'b11;

    // multiplies allowed between issue and bus transfer
    localparam int DEFAULT_QUEUE_DEPTH = 8;

endpackage

`default_nettype wire

// ==== verilog/mul_pipe_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface mul_pipe_if;

    logic                valid;
    // operand magnitudes
    mul_pkg::word_t      op_a;
    mul_pkg::word_t      op_b;
    mul_pkg::dword_t     product;
    // result needs two's complement negation
    logic                negate;
    mul_pkg::mul_funct_t funct;
    mul_pkg::preg_t      preg;
    mul_pkg::rs_id_t     rs_id;
    mul_pkg::pc_t        pc;

    modport source (
        output valid, op_a, op_b, product, negate, funct, preg, rs_id, pc
    );

    modport sink (
        input valid, op_a, op_b, product, negate, funct, preg, rs_id, pc
    );

endinterface

`default_nettype wire

// ==== verilog/mul_issue_decode.sv ====
`timescale 1ns/1ns
`default_nettype none

module mul_issue_decode #(
    parameter int QUEUE_DEPTH = mul_pkg::DEFAULT_QUEUE_DEPTH
) (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      issue_valid,
    output logic                     issue_ready,
    input  wire mul_pkg::mul_funct_t issue_funct,
    input  wire mul_pkg::word_t      issue_a,
    input  wire mul_pkg::word_t      issue_b,
    input  wire mul_pkg::preg_t      issue_preg,
    input  wire mul_pkg::rs_id_t     issue_rs,
    input  wire mul_pkg::pc_t        issue_pc,
    input  wire                      retire,
    mul_pipe_if.source               dec
);

    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    logic [CNT_W-1:0] in_flight;
    logic             accept;
    logic             a_signed;
    logic             b_signed;
    logic             a_neg;
    logic             b_neg;
    mul_pkg::word_t   mag_a;
    mul_pkg::word_t   mag_b;

    assign issue_ready = (in_flight != CNT_W'(QUEUE_DEPTH));
    assign accept      = issue_valid && issue_ready;

    // MULH signs both operands, MULHSU only rs1
    assign a_signed = (issue_funct == mul_pkg::FUNCT_MULH) ||
                      (issue_funct == mul_pkg::FUNCT_MULHSU);
    assign b_signed = (issue_funct == mul_pkg::FUNCT_MULH);

    assign a_neg = a_signed && issue_a[31];
    assign b_neg = b_signed && issue_b[31];

    // most negative value maps onto itself as unsigned 2^31
    assign mag_a = a_neg ? -issue_a : issue_a;
    assign mag_b = b_neg ? -issue_b : issue_b;

    // credits for every multiply not yet on the bus
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            in_flight <= '0;
        end else if (accept && !retire) begin
            in_flight <= in_flight + 1'b1;
        end else if (!accept && retire) begin
            in_flight <= in_flight - 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dec.valid <= 1'b0;
        end else begin
            dec.valid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            dec.op_a   <= mag_a;
            dec.op_b   <= mag_b;
            dec.negate <= a_neg ^ b_neg;
            dec.funct  <= issue_funct;
            dec.preg   <= issue_preg;
            dec.rs_id  <= issue_rs;
            dec.pc     <= issue_pc;
        end
    end

    // product is formed downstream
    assign dec.product = '0;

    // retire pulses come from the result queue
    assert property (@(posedge clk) disable iff (rst) in_flight <= CNT_W'(QUEUE_DEPTH));

endmodule

`default_nettype wire

// ==== verilog/csa_tree_execute.sv ====
`timescale 1ns/1ns
`default_nettype none

module csa_tree_execute (
    input  wire        clk,
    input  wire        rst,
    mul_pipe_if.sink   dec,
    mul_pipe_if.source exe
);

    mul_pkg::dword_t     pp       [32];
    mul_pkg::dword_t     s1_sum_d [16];
    mul_pkg::dword_t     s1_cry_d [16];
    mul_pkg::dword_t     s1_sum   [16];
    mul_pkg::dword_t     s1_cry   [16];
    mul_pkg::dword_t     s2_sum_d [8];
    mul_pkg::dword_t     s2_cry_d [8];
    mul_pkg::dword_t     s2_sum   [8];
    mul_pkg::dword_t     s2_cry   [8];
    mul_pkg::dword_t     s3_sum_d [4];
    mul_pkg::dword_t     s3_cry_d [4];
    mul_pkg::dword_t     s3_sum   [4];
    mul_pkg::dword_t     s3_cry   [4];
    mul_pkg::dword_t     s4_sum_d [2];
    mul_pkg::dword_t     s4_cry_d [2];
    mul_pkg::dword_t     s4_sum   [2];
    mul_pkg::dword_t     s4_cry   [2];
    mul_pkg::dword_t     fin_sum;
    mul_pkg::dword_t     fin_cry;

    // side band, one entry per CSA stage
    logic [3:0]          v_q;
    logic                neg_q  [4];
    mul_pkg::mul_funct_t fn_q   [4];
    mul_pkg::preg_t      preg_q [4];
    mul_pkg::rs_id_t     rs_q   [4];
    mul_pkg::pc_t        pc_q   [4];

    // 3:2 compressor, carry already shifted to its weight
    function automatic void csa3(input mul_pkg::dword_t a, input mul_pkg::dword_t b,
                                 input mul_pkg::dword_t c, output mul_pkg::dword_t sum,
                                 output mul_pkg::dword_t cry);
        sum = a ^ b ^ c;
        cry = ((a & b) | (b & c) | (a & c)) << 1;
    endfunction

    // two sum/carry pairs down to one
    function automatic void csa42(input mul_pkg::dword_t w, input mul_pkg::dword_t x,
                                  input mul_pkg::dword_t y, input mul_pkg::dword_t z,
                                  output mul_pkg::dword_t sum, output mul_pkg::dword_t cry);
        mul_pkg::dword_t t_sum;
        mul_pkg::dword_t t_cry;
        csa3(w, x, y, t_sum, t_cry);
        csa3(t_sum, t_cry, z, sum, cry);
    endfunction

    always_comb begin
        for (int i = 0; i < 32; i++) begin
            pp[i] = dec.op_b[i] ? (mul_pkg::dword_t'(dec.op_a) << i) : '0;
        end
        for (int i = 0; i < 16; i++) begin
            csa3(pp[2*i], pp[2*i+1], '0, s1_sum_d[i], s1_cry_d[i]);
        end
    end

    always_comb begin
        for (int i = 0; i < 8; i++) begin
            csa42(s1_sum[2*i], s1_cry[2*i], s1_sum[2*i+1], s1_cry[2*i+1],
                  s2_sum_d[i], s2_cry_d[i]);
        end
        for (int i = 0; i < 4; i++) begin
            csa42(s2_sum[2*i], s2_cry[2*i], s2_sum[2*i+1], s2_cry[2*i+1],
                  s3_sum_d[i], s3_cry_d[i]);
        end
        for (int i = 0; i < 2; i++) begin
            csa42(s3_sum[2*i], s3_cry[2*i], s3_sum[2*i+1], s3_cry[2*i+1],
                  s4_sum_d[i], s4_cry_d[i]);
        end
        // last pair merge ahead of the carry-propagate add
        csa42(s4_sum[0], s4_cry[0], s4_sum[1], s4_cry[1], fin_sum, fin_cry);
    end

    always_ff @(posedge clk) begin
        s1_sum <= s1_sum_d;
        s1_cry <= s1_cry_d;
        s2_sum <= s2_sum_d;
        s2_cry <= s2_cry_d;
        s3_sum <= s3_sum_d;
        s3_cry <= s3_cry_d;
        s4_sum <= s4_sum_d;
        s4_cry <= s4_cry_d;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            v_q       <= '0;
            exe.valid <= 1'b0;
        end else begin
            v_q       <= {v_q[2:0], dec.valid};
            exe.valid <= v_q[3];
        end
    end

    always_ff @(posedge clk) begin
        neg_q[0]  <= dec.negate;
        fn_q[0]   <= dec.funct;
        preg_q[0] <= dec.preg;
        rs_q[0]   <= dec.rs_id;
        pc_q[0]   <= dec.pc;
        for (int k = 1; k < 4; k++) begin
            neg_q[k]  <= neg_q[k-1];
            fn_q[k]   <= fn_q[k-1];
            preg_q[k] <= preg_q[k-1];
            rs_q[k]   <= rs_q[k-1];
            pc_q[k]   <= pc_q[k-1];
        end
    end

    always_ff @(posedge clk) begin
        exe.product <= fin_sum + fin_cry;
        exe.negate  <= neg_q[3];
        exe.funct   <= fn_q[3];
        exe.preg    <= preg_q[3];
        exe.rs_id   <= rs_q[3];
        exe.pc      <= pc_q[3];
    end

    // magnitudes are consumed here
    assign exe.op_a = '0;
    assign exe.op_b = '0;

    // the result queue takes every cycle of exe valid as a push
    assert property (@(posedge clk) disable iff (rst) !$isunknown(exe.valid));

endmodule

`default_nettype wire

// ==== verilog/mul_result_queue.sv ====
`timescale 1ns/1ns
`default_nettype none

module mul_result_queue #(
    parameter int QUEUE_DEPTH = mul_pkg::DEFAULT_QUEUE_DEPTH
) (
    input  wire              clk,
    input  wire              rst,
    input  wire              cdb_grant,
    mul_pipe_if.sink         exe,
    output logic             retire,
    output logic             cdb_valid,
    output mul_pkg::word_t   cdb_value,
    output mul_pkg::preg_t   cdb_preg,
    output mul_pkg::rs_id_t  cdb_rs,
    output mul_pkg::pc_t     cdb_pc
);

    localparam int PTR_W = $clog2(QUEUE_DEPTH);
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    mul_pkg::dword_t  signed_product;
    mul_pkg::word_t   result_word;

    mul_pkg::word_t   q_value [QUEUE_DEPTH];
    mul_pkg::preg_t   q_preg  [QUEUE_DEPTH];
    mul_pkg::rs_id_t  q_rs    [QUEUE_DEPTH];
    mul_pkg::pc_t     q_pc    [QUEUE_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    // sign correction on the full product before word select
    assign signed_product = exe.negate ? -exe.product : exe.product;
    assign result_word    = (exe.funct == mul_pkg::FUNCT_MUL) ? signed_product[31:0]
                                                              : signed_product[63:32];

    assign push = exe.valid;
    assign pop  = cdb_valid && cdb_grant;

    always_ff @(posedge clk) begin
        if (push) begin
            q_value[wr_ptr] <= result_word;
            q_preg[wr_ptr]  <= exe.preg;
            q_rs[wr_ptr]    <= exe.rs_id;
            q_pc[wr_ptr]    <= exe.pc;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count <= '0;
        end else begin
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // head of queue held on the bus until granted
    assign cdb_valid = (count != '0);
    assign cdb_value = q_value[rd_ptr];
    assign cdb_preg  = q_preg[rd_ptr];
    assign cdb_rs    = q_rs[rd_ptr];
    assign cdb_pc    = q_pc[rd_ptr];

    // frees one issue credit
    assign retire = pop;

    // issue credits keep room for everything still in the tree
    assert property (@(posedge clk) disable iff (rst) push |-> count < CNT_W'(QUEUE_DEPTH));

endmodule

`default_nettype wire

// ==== verilog/mul_unit_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module mul_unit_top #(
    parameter int QUEUE_DEPTH = mul_pkg::DEFAULT_QUEUE_DEPTH
) (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      issue_valid,
    output logic                     issue_ready,
    input  wire mul_pkg::mul_funct_t issue_funct,
    input  wire mul_pkg::word_t      issue_a,
    input  wire mul_pkg::word_t      issue_b,
    input  wire mul_pkg::preg_t      issue_preg,
    input  wire mul_pkg::rs_id_t     issue_rs,
    input  wire mul_pkg::pc_t        issue_pc,
    input  wire                      cdb_grant,
    output logic                     cdb_valid,
    output mul_pkg::word_t           cdb_value,
    output mul_pkg::preg_t           cdb_preg,
    output mul_pkg::rs_id_t          cdb_rs,
    output mul_pkg::pc_t             cdb_pc
);

    logic retire;

    mul_pipe_if dec_pipe ();
    mul_pipe_if exe_pipe ();

    // decode, five tree stages and the queue write
    if (QUEUE_DEPTH < 7) begin : g_depth_check
        $error("QUEUE_DEPTH below pipeline depth");
    end

    mul_issue_decode #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_decode (
        .clk         (clk),
        .rst         (rst),
        .issue_valid (issue_valid),
        .issue_ready (issue_ready),
        .issue_funct (issue_funct),
        .issue_a     (issue_a),
        .issue_b     (issue_b),
        .issue_preg  (issue_preg),
        .issue_rs    (issue_rs),
        .issue_pc    (issue_pc),
        .retire      (retire),
        .dec         (dec_pipe.source)
    );

    csa_tree_execute u_execute (
        .clk (clk),
        .rst (rst),
        .dec (dec_pipe.sink),
        .exe (exe_pipe.source)
    );

    mul_result_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_result (
        .clk       (clk),
        .rst       (rst),
        .cdb_grant (cdb_grant),
        .exe       (exe_pipe.sink),
        .retire    (retire),
        .cdb_valid (cdb_valid),
        .cdb_value (cdb_value),
        .cdb_preg  (cdb_preg),
        .cdb_rs    (cdb_rs),
        .cdb_pc    (cdb_pc)
    );

endmodule

`default_nettype wire

// ==== verification/mul_unit_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module mul_unit_tb;

    localparam int QUEUE_DEPTH = mul_pkg::DEFAULT_QUEUE_DEPTH;
    // 200, 25, 152 and 100 ops, then depth + 4 and a single one
    localparam int TOTAL_OPS   = 477 + QUEUE_DEPTH + 5;

    logic                clk;
    logic                rst;
    logic                issue_valid;
    logic                issue_ready;
    mul_pkg::mul_funct_t issue_funct;
    mul_pkg::word_t      issue_a;
    mul_pkg::word_t      issue_b;
    mul_pkg::preg_t      issue_preg;
    mul_pkg::rs_id_t     issue_rs;
    mul_pkg::pc_t        issue_pc;
    logic                cdb_grant;
    logic                cdb_valid;
    mul_pkg::word_t      cdb_value;
    mul_pkg::preg_t      cdb_preg;
    mul_pkg::rs_id_t     cdb_rs;
    mul_pkg::pc_t        cdb_pc;

    // expected results in issue order
    mul_pkg::word_t      exp_word [$];
    mul_pkg::preg_t      exp_preg [$];
    mul_pkg::rs_id_t     exp_rs   [$];
    mul_pkg::pc_t        exp_pc   [$];

    integer seed         = 32'h7014f1d8;
    int     errors       = 0;
    int     checks       = 0;
    int     tests        = 0;
    int     cycle        = 0;
    int     accept_count = 0;
    int     accept_cycle = 0;
    int     xfer_count   = 0;
    int     xfer_cycle   = 0;

    mul_unit_top #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) dut (
        .clk         (clk),
        .rst         (rst),
        .issue_valid (issue_valid),
        .issue_ready (issue_ready),
        .issue_funct (issue_funct),
        .issue_a     (issue_a),
        .issue_b     (issue_b),
        .issue_preg  (issue_preg),
        .issue_rs    (issue_rs),
        .issue_pc    (issue_pc),
        .cdb_grant   (cdb_grant),
        .cdb_valid   (cdb_valid),
        .cdb_value   (cdb_value),
        .cdb_preg    (cdb_preg),
        .cdb_rs      (cdb_rs),
        .cdb_pc      (cdb_pc)
    );

    always #10 clk = ~clk;

    // full 64-bit product with each operand extended per its signedness
    function automatic mul_pkg::word_t ref_mul(input mul_pkg::mul_funct_t f,
                                               input mul_pkg::word_t a,
                                               input mul_pkg::word_t b);
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic signed [63:0] ua;
        logic signed [63:0] ub;
        logic signed [63:0] p;
        sa = {{32{a[31]}}, a};
        sb = {{32{b[31]}}, b};
        ua = {32'b0, a};
        ub = {32'b0, b};
        case (f)
            mul_pkg::FUNCT_MUL:    p = ua * ub;
            mul_pkg::FUNCT_MULH:   p = sa * sb;
            mul_pkg::FUNCT_MULHSU: p = sa * ub;
            default:               p = ua * ub;
        endcase
        if (f == mul_pkg::FUNCT_MUL) begin
            return p[31:0];
        end
        return p[63:32];
    endfunction

    task automatic check_word(input string name, input mul_pkg::word_t exp,
                              input mul_pkg::word_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_preg(input string name, input mul_pkg::preg_t exp,
                              input mul_pkg::preg_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_rs(input string name, input mul_pkg::rs_id_t exp,
                            input mul_pkg::rs_id_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_pc(input string name, input mul_pkg::pc_t exp, input mul_pkg::pc_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error at %0t ns: %s expected %b, got %b", $time, name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        checks++;
        if (act != exp) begin
            errors++;
            $display("** Error at %0t ns: %s expected %0d, got %0d", $time, name, exp, act);
        end
    endtask

    // scoreboard samples at the edge before any register moves
    always @(posedge clk) begin
        cycle = cycle + 1;
        if (!rst && cdb_valid && cdb_grant) begin
            xfer_count = xfer_count + 1;
            xfer_cycle = cycle;
            if (exp_word.size() == 0) begin
                errors++;
                $display("bus transfer at %0t ns while no result was expected", $time);
            end else begin
                check_word("cdb_value", exp_word.pop_front(), cdb_value);
                check_preg("cdb_preg", exp_preg.pop_front(), cdb_preg);
                check_rs("cdb_rs", exp_rs.pop_front(), cdb_rs);
                check_pc("cdb_pc", exp_pc.pop_front(), cdb_pc);
            end
        end
        if (!rst && issue_valid && issue_ready) begin
            accept_count = accept_count + 1;
            accept_cycle = cycle;
            exp_word.push_back(ref_mul(issue_funct, issue_a, issue_b));
            exp_preg.push_back(issue_preg);
            exp_rs.push_back(issue_rs);
            exp_pc.push_back(issue_pc);
        end
    end

    // holds the operation on the port until the DUT accepts it
    task automatic issue_op(input mul_pkg::mul_funct_t f, input mul_pkg::word_t a,
                            input mul_pkg::word_t b, input int tag);
        int start;
        start       = accept_count;
        issue_valid = 1'b1;
        issue_funct = f;
        issue_a     = a;
        issue_b     = b;
        issue_preg  = 7'(tag);
        issue_rs    = 7'(tag + 5);
        issue_pc    = 32'h0000_1000 + 32'(tag << 2);
        while (accept_count == start) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic drain();
        issue_valid = 1'b0;
        while (exp_word.size() != 0) begin
            @(posedge clk);
            #1;
        end
        repeat (2) @(posedge clk);
        #1;
    endtask

    task automatic end_test(input string name, input int err_start);
        tests++;
        $display("test %0d %s finished, %0d errors", tests, name, errors - err_start);
    endtask

    initial begin
        mul_pkg::word_t corner [5];
        mul_pkg::word_t top    [4];
        int             err0;
        int             xfer0;
        int             acc0;
        corner = '{32'h0000_0000, 32'h0000_0001, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff};
        top    = '{32'h8000_0000, 32'hffff_ffff, 32'h8000_0001, 32'hc000_0000};
        clk         = 1'b0;
        rst         = 1'b1;
        issue_valid = 1'b0;
        issue_funct = mul_pkg::FUNCT_MUL;
        issue_a     = '0;
        issue_b     = '0;
        issue_preg  = '0;
        issue_rs    = '0;
        issue_pc    = '0;
        cdb_grant   = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rst       = 1'b0;
        cdb_grant = 1'b1;

        err0 = errors;
        for (int i = 0; i < 200; i++) begin
            issue_op(mul_pkg::FUNCT_MUL, $random(seed), $random(seed), i);
        end
        drain();
        end_test("mul random", err0);

        err0 = errors;
        for (int i = 0; i < 25; i++) begin
            issue_op(mul_pkg::FUNCT_MULH, corner[i / 5], corner[i % 5], i);
        end
        drain();
        end_test("mulh corners", err0);

        err0 = errors;
        for (int i = 0; i < 120; i++) begin
            issue_op((i < 60) ? mul_pkg::FUNCT_MULHSU : mul_pkg::FUNCT_MULHU,
                     $random(seed), $random(seed), i);
        end
        for (int i = 0; i < 32; i++) begin
            issue_op((i < 16) ? mul_pkg::FUNCT_MULHSU : mul_pkg::FUNCT_MULHU,
                     top[(i / 4) % 4], top[i % 4], i);
        end
        drain();
        end_test("mulhsu and mulhu", err0);

        // tags stay unique over 100 ops
        err0 = errors;
        for (int i = 0; i < 100; i++) begin
            issue_op(mul_pkg::mul_funct_t'($random(seed)), $random(seed), $random(seed), i);
        end
        drain();
        end_test("back-to-back tags", err0);

        err0      = errors;
        xfer0     = xfer_count;
        acc0      = accept_count;
        cdb_grant = 1'b0;
        for (int i = 0; i < QUEUE_DEPTH; i++) begin
            check_bit("issue_ready", 1'b1, issue_ready);
            issue_op(mul_pkg::mul_funct_t'($random(seed)), $random(seed), $random(seed), i);
        end
        check_bit("issue_ready", 1'b0, issue_ready);
        fork
            for (int i = 0; i < 4; i++) begin
                issue_op(mul_pkg::mul_funct_t'($random(seed)), $random(seed),
                         $random(seed), QUEUE_DEPTH + i);
            end
            begin
                repeat (20) @(posedge clk);
                #1;
                check_count("accepts while stalled", QUEUE_DEPTH, accept_count - acc0);
                cdb_grant = 1'b1;
            end
        join
        drain();
        check_count("results drained", QUEUE_DEPTH + 4, xfer_count - xfer0);
        end_test("back-pressure", err0);

        err0 = errors;
        repeat (5) @(posedge clk);
        #1;
        issue_op(mul_pkg::FUNCT_MUL, 32'd1234, 32'd5678, 77);
        drain();
        check_count("cdb_valid latency", 7, xfer_cycle - accept_cycle);
        end_test("idle latency", err0);

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        repeat (TOTAL_OPS * 40) @(posedge clk);
        $display("run timed out after %0d cycles with %0d results still expected",
                 TOTAL_OPS * 40, exp_word.size());
        $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
verilog/mul_pkg.sv
verilog/mul_pipe_if.sv
verilog/mul_issue_decode.sv
verilog/csa_tree_execute.sv
verilog/mul_result_queue.sv
verilog/mul_unit_top.sv
verification/mul_unit_tb.sv

// ==== Makefile ====
TOP := mul_unit_tb

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): src.f $(wildcard verilog/*.sv verification/*.sv)
	verilator --binary --timing --assert -Wno-fatal -f src.f --top-module $(TOP)

# pass only if the pass line shows up in the simulation output
run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep "Simulation PASSED" > /dev/null

lint:
	verilator --lint-only -Wall --timing -f src.f --top-module mul_unit_top

clean:
	rm -rf obj_dir
